// File: Makefile
# verilator build and run of the fp classifier testbench

VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := fpClassTb
FILELIST  := src.f
OBJDIR    := obj_dir
PASSMSG   := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)

// File: bench/fpClassTb.sv
// testbench for the fp classifier, drives wishbone writes and reads and checks results against a model
`timescale 1ns/1ps

module fpClassTb;

  localparam int clkPeriod = 4;
  // reset read, ten doubles, twelve narrow operands, fill test, result address
  localparam int numTxn = 1 + 20 + 24 + 10 + 2;

  logic clk;
  logic rstN;
  fpPkg::wbReqT req;
  fpPkg::wbRspT rsp;

  int errors;
  int checks;
  logic [31:0] lcgState;
  // operands of the fill test, in write order
  logic [63:0] fillOps [4];

  fpClassTop #(.fifoDepth(4)) u_dut (
    .clk(clk),
    .rstN(rstN),
    .req(req),
    .rsp(rsp)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  // ----------------------------------------------------------
  // stimulus helpers
  // ----------------------------------------------------------

  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic logic [51:0] randFrac();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcgNext();
    lo = lcgNext();
    return {hi[19:0], lo};
  endfunction

  // double exponent of a normal number, 1 to 2046
  function automatic logic [10:0] randExp();
    logic [31:0] r;
    r = lcgNext();
    return 11'(r % 32'd2046) + 11'd1;
  endfunction

  // narrow formats are boxed in ones
  function automatic logic [63:0] packOp(fpPkg::fmtT fmt, logic sgn, logic [10:0] e,
                                         logic [51:0] f);
    case (fmt)
      fpPkg::fmtS: return {32'hffff_ffff, sgn, e[7:0], f[22:0]};
      fpPkg::fmtH: return {48'hffff_ffff_ffff, sgn, e[4:0], f[9:0]};
      default: return {sgn, e, f};
    endcase
  endfunction

  // ----------------------------------------------------------
  // reference model from the ieee field rules
  // ----------------------------------------------------------

  function automatic logic [63:0] expectWord(logic [63:0] op, fpPkg::fmtT fmt);
    int ew;
    int fw;
    int len;
    int bias;
    int expD;
    int cls;
    logic [63:0] fieldE;
    logic [63:0] fieldF;
    logic [63:0] eMax;
    logic boxOk;
    logic sgn;
    logic [63:0] w;
    ew = (fmt == fpPkg::fmtD) ? 11 : (fmt == fpPkg::fmtS) ? 8 : 5;
    fw = (fmt == fpPkg::fmtD) ? 52 : (fmt == fpPkg::fmtS) ? 23 : 10;
    len = 1 + ew + fw;
    bias = (1 << (ew - 1)) - 1;
    fieldF = op & ((64'd1 << fw) - 64'd1);
    fieldE = (op >> fw) & ((64'd1 << ew) - 64'd1);
    eMax = (64'd1 << ew) - 64'd1;
    sgn = op[len - 1];
    boxOk = (len == 64) || ((op >> len) == ({64{1'b1}} >> len));
    // zero and subnormal take effective exponent 1 before the rebias
    expD = ((fieldE == '0) ? 1 : int'(fieldE)) - bias + 1023;
    if (!boxOk) begin
      cls = fpPkg::qNaN;
    end else if (fieldE == eMax && fieldF == '0) begin
      cls = sgn ? fpPkg::negInf : fpPkg::posInf;
    end else if (fieldE == eMax) begin
      // quiet bit is the top fraction bit
      cls = fieldF[fw - 1] ? fpPkg::qNaN : fpPkg::sNaN;
    end else if (fieldE == '0 && fieldF == '0) begin
      cls = sgn ? fpPkg::negZero : fpPkg::posZero;
    end else if (fieldE == '0) begin
      cls = sgn ? fpPkg::negSub : fpPkg::posSub;
    end else begin
      cls = sgn ? fpPkg::negNorm : fpPkg::posNorm;
    end
    w = '0;
    w[63] = 1'b1;
    w[26:16] = expD[10:0];
    w[cls] = 1'b1;
    return w;
  endfunction

  // ----------------------------------------------------------
  // wishbone master
  // ----------------------------------------------------------

  // returns at the falling edge that shows the response
  task automatic waitResponse(input string what);
    int waited;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!rsp.ack && !rsp.err && waited < 20);
    if (!rsp.ack && !rsp.err) begin
      $display("no response to bus %s within 20 cycles", what);
      errors++;
    end
  endtask

  task automatic busWrite(input logic [63:0] dat, input fpPkg::fmtT adr, output logic gotErr);
    @(posedge clk);
    #1;
    req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
    waitResponse("write");
    gotErr = rsp.err;
    // stb drops after the edge, stays low a full cycle
    @(posedge clk);
    #1;
    req = '0;
  endtask

  task automatic busRead(output logic [63:0] dat, output logic gotErr);
    @(posedge clk);
    #1;
    req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: 2'b11, dat: '0};
    waitResponse("read");
    dat = rsp.dat;
    gotErr = rsp.err;
    @(posedge clk);
    #1;
    req = '0;
  endtask

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------

  task automatic writeExpect(input logic [63:0] op, input fpPkg::fmtT fmt, input logic expErr);
    logic gotErr;
    busWrite(op, fmt, gotErr);
    checks++;
    assert (gotErr == expErr) else begin
      $display("FAIL rsp.err got %h expected %h", gotErr, expErr);
      errors++;
    end
  endtask

  task automatic readExpect(input logic [63:0] expected);
    logic [63:0] got;
    logic gotErr;
    busRead(got, gotErr);
    checks++;
    // reads never answer with err
    assert (!gotErr) else begin
      $display("FAIL rsp.err got %h expected %h", gotErr, 1'b0);
      errors++;
    end
    assert (got == expected) else begin
      $display("FAIL rsp.dat got %h expected %h", got, expected);
      errors++;
    end
  endtask

  task automatic roundTrip(input logic [63:0] op, input fpPkg::fmtT fmt);
    writeExpect(op, fmt, 1'b0);
    readExpect(expectWord(op, fmt));
  endtask

  // six cases of one narrow format, the last one badly boxed
  task automatic narrowSet(input fpPkg::fmtT fmt);
    logic [10:0] eMax;
    logic [10:0] eNorm;
    logic [51:0] rf;
    eMax = (fmt == fpPkg::fmtS) ? 11'h0ff : 11'h01f;
    eNorm = (fmt == fpPkg::fmtS) ? 11'h080 : 11'h00f;
    rf = randFrac();
    roundTrip(packOp(fmt, 1'b0, eNorm, rf), fmt);
    roundTrip(packOp(fmt, 1'b1, 11'h000, {rf[51:1], 1'b1}), fmt);
    roundTrip(packOp(fmt, 1'b0, 11'h000, '0), fmt);
    roundTrip(packOp(fmt, 1'b1, eMax, '0), fmt);
    roundTrip(packOp(fmt, 1'b0, eMax, 52'd1), fmt);
    roundTrip((fmt == fpPkg::fmtS) ? 64'h0000_0000_3f80_0000 : 64'hffff_ffff_0000_3c00, fmt);
  endtask

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------

  initial begin
    logic [51:0] rf;
    req = '0;
    rstN = 1'b0;
    errors = 0;
    checks = 0;
    lcgState = 32'd13;
    repeat (4) @(posedge clk);
    #1;
    rstN = 1'b1;

    // nothing buffered yet
    readExpect(64'h0);

    // doubles of every class
    roundTrip(packOp(fpPkg::fmtD, 1'b1, 11'h7ff, '0), fpPkg::fmtD);
    roundTrip(packOp(fpPkg::fmtD, 1'b0, 11'h7ff, '0), fpPkg::fmtD);
    roundTrip(packOp(fpPkg::fmtD, 1'b1, randExp(), randFrac()), fpPkg::fmtD);
    roundTrip(packOp(fpPkg::fmtD, 1'b0, randExp(), randFrac()), fpPkg::fmtD);
    rf = randFrac();
    roundTrip(packOp(fpPkg::fmtD, 1'b1, 11'h000, {rf[51:1], 1'b1}), fpPkg::fmtD);
    roundTrip(packOp(fpPkg::fmtD, 1'b0, 11'h000, {1'b1, rf[50:0]}), fpPkg::fmtD);
    roundTrip(packOp(fpPkg::fmtD, 1'b1, 11'h000, '0), fpPkg::fmtD);
    roundTrip(packOp(fpPkg::fmtD, 1'b0, 11'h000, '0), fpPkg::fmtD);
    roundTrip(packOp(fpPkg::fmtD, 1'b0, 11'h7ff, {1'b0, rf[50:1], 1'b1}), fpPkg::fmtD);
    roundTrip(packOp(fpPkg::fmtD, 1'b1, 11'h7ff, {1'b1, rf[50:0]}), fpPkg::fmtD);

    narrowSet(fpPkg::fmtS);
    narrowSet(fpPkg::fmtH);

    // fill the fifo, the fifth write overflows
    for (int i = 0; i < 4; i++) begin
      fillOps[i] = packOp(fpPkg::fmtD, i[0], randExp(), randFrac());
      writeExpect(fillOps[i], fpPkg::fmtD, 1'b0);
    end
    writeExpect(packOp(fpPkg::fmtD, 1'b0, 11'h400, '0), fpPkg::fmtD, 1'b1);
    for (int i = 0; i < 4; i++) begin
      readExpect(expectWord(fillOps[i], fpPkg::fmtD));
    end
    readExpect(64'h0);

    // result address holds no operand
    writeExpect(64'h0000_0000_0000_1234, 2'b11, 1'b0);
    readExpect(64'h0);

    repeat (4) @(posedge clk);
    $display("checks %0d errors %0d assertion failures %0d",
             checks, errors, u_dut.uProps.failCount);
    if (errors == 0 && u_dut.uProps.failCount == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // watchdog, bounded by the number of bus transactions
  initial begin
    repeat (numTxn * 200) @(posedge clk);
    $display("watchdog expired after %0d cycles, checks %0d errors %0d",
             numTxn * 200, checks, errors);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: bench/fpClass_props.sv
// protocol and result checker bound into the fp classifier top level
`timescale 1ns/1ps

module fpClassProps (
  input logic clk,
  input logic rstN,
  input fpPkg::wbReqT req,
  input fpPkg::wbRspT rsp
);

  // failures so far, summed into the closing line of the testbench
  int unsigned failCount = 0;

  // ack and err exclude each other
  ackErrExclusive: assert property (@(posedge clk) disable iff (!rstN)
    !(rsp.ack && rsp.err))
    else begin
      $error("ack and err high in the same cycle");
      failCount++;
    end

  // a slave answers only inside a strobed cycle
  responseInCycle: assert property (@(posedge clk) disable iff (!rstN)
    (rsp.ack || rsp.err) |-> (req.cyc && req.stb))
    else begin
      $error("response without cyc and stb");
      failCount++;
    end

  // no response while reset holds
  quietInReset: assert property (@(posedge clk)
    !rstN |-> (rsp.ack !== 1'b1 && rsp.err !== 1'b1))
    else begin
      $error("response during reset");
      failCount++;
    end

  // a valid result carries exactly one class
  oneClass: assert property (@(posedge clk) disable iff (!rstN)
    (rsp.ack && rsp.dat[fpPkg::resValidBit]) |-> $onehot(rsp.dat[9:0]))
    else begin
      $error("valid result without exactly one fclass bit");
      failCount++;
    end

endmodule

bind fpClassTop fpClassProps uProps (
  .clk(clk),
  .rstN(rstN),
  .req(req),
  .rsp(rsp)
);

// File: source/fpClassTop.sv
// top level of the fp classifier joining the write port, record fifo and read side on one bus
`timescale 1ns/1ps

module fpClassTop #(
  parameter int fifoDepth = 4
) (
  input logic clk,
  input logic rstN,
  input fpPkg::wbReqT req,
  output fpPkg::wbRspT rsp
);

  fpPkg::wbRspT wrRsp;
  fpPkg::wbRspT rdRsp;
  fpPkg::unpackedT wrData;
  fpPkg::unpackedT rdData;
  logic push;
  logic pop;
  logic full;
  logic empty;

  // write cycles only
  wbOperandPort uPort (
    .clk(clk),
    .rstN(rstN),
    .req(req),
    .rsp(wrRsp),
    .full(full),
    .push(push),
    .wrData(wrData)
  );

  recordFifo #(
    .depth(fifoDepth),
    .T(fpPkg::unpackedT)
  ) uFifo (
    .clk(clk),
    .rstN(rstN),
    .push(push),
    .wrData(wrData),
    .pop(pop),
    .rdData(rdData),
    .full(full),
    .empty(empty)
  );

  // read cycles only
  fpClassify uClassify (
    .clk(clk),
    .rstN(rstN),
    .req(req),
    .rsp(rdRsp),
    .empty(empty),
    .pop(pop),
    .rdData(rdData)
  );

  // we selects one side, the other stays all zero
  assign rsp = wrRsp | rdRsp;

endmodule

// File: source/fpClassify.sv
// wishbone read side that pops the head record and returns its fclass mask and exponent
`timescale 1ns/1ps

module fpClassify (
  input logic clk,
  input logic rstN,
  input fpPkg::wbReqT req,
  output fpPkg::wbRspT rsp,
  input logic empty,
  output logic pop,
  // head of the record fifo
  input fpPkg::unpackedT rdData
);

  logic rdReq;
  // response given, waiting for stb to drop
  logic busy;
  logic ackQ;
  logic [fpPkg::flen-1:0] datQ;
  logic [fpPkg::flen-1:0] result;
  fpPkg::fclassT mask;
  logic isNum;
  logic isInf;
  logic isNorm;
  logic isSub;
  logic isZero;

  // adr is not decoded on reads
  assign rdReq = req.cyc & req.stb & ~req.we & ~busy;

  // head leaves the fifo at the edge that registers its result
  assign pop = rdReq & ~empty;

  // ----------------------------------------------------------
  // fclass decode
  // ----------------------------------------------------------

  // nan wins over every other class
  assign isNum = ~rdData.nan;
  assign isInf = rdData.inf & isNum;
  assign isNorm = rdData.expNonZero & ~rdData.inf & isNum;
  assign isSub = ~rdData.expNonZero & ~rdData.fracZero & isNum;
  assign isZero = rdData.zero & isNum;

  always_comb begin
    mask = '0;
    mask[fpPkg::negInf] = isInf & rdData.sgn;
    mask[fpPkg::negNorm] = isNorm & rdData.sgn;
    mask[fpPkg::negSub] = isSub & rdData.sgn;
    mask[fpPkg::negZero] = isZero & rdData.sgn;
    mask[fpPkg::posZero] = isZero & ~rdData.sgn;
    mask[fpPkg::posSub] = isSub & ~rdData.sgn;
    mask[fpPkg::posNorm] = isNorm & ~rdData.sgn;
    mask[fpPkg::posInf] = isInf & ~rdData.sgn;
    mask[fpPkg::sNaN] = rdData.snan;
    mask[fpPkg::qNaN] = rdData.nan & ~rdData.snan;
  end

  // valid bit, exponent and mask, all zero when nothing is buffered
  always_comb begin
    result = '0;
    if (!empty) begin
      result[fpPkg::resValidBit] = 1'b1;
      result[fpPkg::resExpLsb +: fpPkg::neD] = rdData.exp;
      result[$bits(fpPkg::fclassT)-1:0] = mask;
    end
  end

  // ----------------------------------------------------------
  // registered response
  // ----------------------------------------------------------

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ackQ <= 1'b0;
      busy <= 1'b0;
    end else begin
      // reads always ack, an empty fifo just clears the valid bit
      ackQ <= rdReq;
      busy <= rdReq | (busy & req.stb);
    end
  end

  always_ff @(posedge clk) begin
    if (rdReq) begin
      datQ <= result;
    end
  end

  assign rsp = '{ack: ackQ, err: 1'b0, dat: datQ};

endmodule

// File: source/fpPkg.sv
// shared widths, format codes, bus records and fclass layout for the fp classifier
package fpPkg;

  // ----------------------------------------------------------
  // operand widths
  // ----------------------------------------------------------

  // register file word, FLEN of the core
  localparam int flen = 64;

  // double precision fields
  localparam int neD = 11;
  localparam int nfD = 52;

  // single precision fields
  localparam int lenS = 32;
  localparam int neS = 8;
  localparam int nfS = 23;

  // half precision fields
  localparam int lenH = 16;
  localparam int neH = 5;
  localparam int nfH = 10;

  // ----------------------------------------------------------
  // format codes, carried on the bus address
  // ----------------------------------------------------------

  typedef logic [1:0] fmtT;

  localparam fmtT fmtS = 2'b00;
  localparam fmtT fmtD = 2'b01;
  localparam fmtT fmtH = 2'b10;
  // quad slot reused as the result address
  localparam fmtT resAdr = 2'b11;

  // ----------------------------------------------------------
  // wishbone classic records
  // ----------------------------------------------------------

  // master to slave
  typedef struct packed {
    logic cyc;
    logic stb;
    logic we;
    logic [1:0] adr;
    logic [flen-1:0] dat;
  } wbReqT;

  // slave to master, one of ack or err per cycle
  typedef struct packed {
    logic ack;
    logic err;
    logic [flen-1:0] dat;
  } wbRspT;

  // unpacked operand, always in double layout
  typedef struct packed {
    logic sgn;
    // exponent with double bias, 1 for zero and subnormal
    logic [neD-1:0] exp;
    // significand with hidden bit
    logic [nfD:0] man;
    logic nan;
    logic snan;
    logic zero;
    logic inf;
    logic expNonZero;
    logic fracZero;
  } unpackedT;

  // ----------------------------------------------------------
  // fclass mask and result word
  // ----------------------------------------------------------

  typedef logic [9:0] fclassT;

  // bit positions as in the riscv fclass instruction
  localparam int negInf = 0;
  localparam int negNorm = 1;
  localparam int negSub = 2;
  localparam int negZero = 3;
  localparam int posZero = 4;
  localparam int posSub = 5;
  localparam int posNorm = 6;
  localparam int posInf = 7;
  localparam int sNaN = 8;
  localparam int qNaN = 9;

  // result word fields, remaining bits read as zero
  localparam int resValidBit = 63;
  localparam int resExpLsb = 16;

endpackage

// File: source/fpUnpack.sv
// combinational unpacker turning a double, single or half register word into a double record
`timescale 1ns/1ps

module fpUnpack (
  // raw register file word
  input logic [fpPkg::flen-1:0] in,
  // format of the word
  input fpPkg::fmtT fmt,
  // fields and characteristics in double layout
  output fpPkg::unpackedT rec
);

  // fraction left aligned to double width
  logic [fpPkg::nfD-1:0] frac;
  // upper bits of a narrow operand not all ones
  logic badNaNBox;
  logic sgn;
  logic expNonZero;
  // exponent all ones, inf or nan
  logic expMax;
  logic [fpPkg::neD-1:0] exp;
  logic fracZero;
  logic nan;

  // ----------------------------------------------------------
  // field extraction per format
  // ----------------------------------------------------------

  // narrow operands must sit in a word of ones
  always_comb begin
    case (fmt)
      fpPkg::fmtS: badNaNBox = ~&in[fpPkg::flen-1:fpPkg::lenS];
      fpPkg::fmtH: badNaNBox = ~&in[fpPkg::flen-1:fpPkg::lenH];
      // double fills the whole word
      default: badNaNBox = 1'b0;
    endcase
  end

  // sign is the top bit of the operand itself
  always_comb begin
    case (fmt)
      fpPkg::fmtS: sgn = in[fpPkg::lenS-1];
      fpPkg::fmtH: sgn = in[fpPkg::lenH-1];
      default: sgn = in[fpPkg::flen-1];
    endcase
  end

  // narrow fractions padded with zeros on the right
  always_comb begin
    case (fmt)
      fpPkg::fmtS: frac = {in[fpPkg::nfS-1:0], {(fpPkg::nfD - fpPkg::nfS){1'b0}}};
      fpPkg::fmtH: frac = {in[fpPkg::nfH-1:0], {(fpPkg::nfD - fpPkg::nfH){1'b0}}};
      default: frac = in[fpPkg::nfD-1:0];
    endcase
  end

  // any exponent bit set
  always_comb begin
    case (fmt)
      fpPkg::fmtS: expNonZero = |in[fpPkg::lenS-2:fpPkg::nfS];
      fpPkg::fmtH: expNonZero = |in[fpPkg::lenH-2:fpPkg::nfH];
      default: expNonZero = |in[fpPkg::flen-2:fpPkg::nfD];
    endcase
  end

  // all exponent bits set
  always_comb begin
    case (fmt)
      fpPkg::fmtS: expMax = &in[fpPkg::lenS-2:fpPkg::nfS];
      fpPkg::fmtH: expMax = &in[fpPkg::lenH-2:fpPkg::nfH];
      default: expMax = &in[fpPkg::flen-2:fpPkg::nfD];
    endcase
  end

  // ----------------------------------------------------------
  // exponent rebias
  // ----------------------------------------------------------

  // adding the bias difference 1023 - 127 = 0b011_1000_0000 to a narrow
  // biased exponent keeps its msb, fills the new upper bits with the
  // inverse of that msb and keeps the low bits
  // a zero exponent gets its lsb forced so the effective value is 1
  always_comb begin
    case (fmt)
      fpPkg::fmtS: exp = {in[fpPkg::lenS-2],
                          {(fpPkg::neD - fpPkg::neS){~in[fpPkg::lenS-2]}},
                          in[fpPkg::lenS-3:fpPkg::nfS+1],
                          in[fpPkg::nfS] | ~expNonZero};
      fpPkg::fmtH: exp = {in[fpPkg::lenH-2],
                          {(fpPkg::neD - fpPkg::neH){~in[fpPkg::lenH-2]}},
                          in[fpPkg::lenH-3:fpPkg::nfH+1],
                          in[fpPkg::nfH] | ~expNonZero};
      // already double biased
      default: exp = {in[fpPkg::flen-2:fpPkg::nfD+1], in[fpPkg::nfD] | ~expNonZero};
    endcase
  end

  // ----------------------------------------------------------
  // characteristics
  // ----------------------------------------------------------

  assign fracZero = ~|frac;

  // a badly boxed operand reads as the canonical quiet nan
  assign nan = (expMax & ~fracZero) | badNaNBox;

  always_comb begin
    rec.sgn = sgn;
    rec.exp = exp;
    // hidden bit is clear for zero and subnormal
    rec.man = {expNonZero, frac};
    rec.nan = nan;
    // signaling when the quiet bit is clear, never for a bad box
    rec.snan = nan & ~frac[fpPkg::nfD-1] & ~badNaNBox;
    rec.zero = ~expNonZero & fracZero;
    rec.inf = expMax & fracZero;
    rec.expNonZero = expNonZero;
    rec.fracZero = fracZero;
  end

endmodule

// File: source/recordFifo.sv
// synchronous circular fifo with a type parameter payload, full and empty flags
`timescale 1ns/1ps

module recordFifo #(
  parameter int depth = 4,
  parameter type T = logic [7:0]
) (
  input logic clk,
  input logic rstN,
  input logic push,
  input T wrData,
  input logic pop,
  // head entry, valid while not empty
  output T rdData,
  output logic full,
  output logic empty
);

  localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
  localparam int cntW = $clog2(depth + 1);

  T mem [depth];
  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [cntW-1:0] count;
  logic doPush;
  logic doPop;

  // push when full and pop when empty are dropped
  assign doPush = push & ~full;
  assign doPop = pop & ~empty;

  assign full = count == cntW'(depth);
  assign empty = count == '0;

  // ----------------------------------------------------------
  // pointers and occupancy
  // ----------------------------------------------------------

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      // wrap at depth so any depth works
      if (doPush) begin
        wrPtr <= (wrPtr == ptrW'(depth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= (rdPtr == ptrW'(depth - 1)) ? '0 : rdPtr + 1'b1;
      end
      // simultaneous push and pop leave count unchanged
      count <= count + cntW'(doPush) - cntW'(doPop);
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (doPush) begin
      mem[wrPtr] <= wrData;
    end
  end

  assign rdData = mem[rdPtr];

endmodule

// File: source/wbOperandPort.sv
// wishbone write side that unpacks the addressed operand and pushes it into the record fifo
`timescale 1ns/1ps

module wbOperandPort (
  input logic clk,
  input logic rstN,
  input fpPkg::wbReqT req,
  output fpPkg::wbRspT rsp,
  // buffer has no free slot
  input logic full,
  output logic push,
  output fpPkg::unpackedT wrData
);

  logic wrReq;
  // response given, waiting for stb to drop
  logic busy;
  logic ackQ;
  logic errQ;
  logic toFifo;
  fpPkg::unpackedT unpacked;

  // new write cycle, one response per strobe
  assign wrReq = req.cyc & req.stb & req.we & ~busy;

  // the result address carries no operand
  assign toFifo = req.adr != fpPkg::resAdr;

  // bus address doubles as the format code
  fpUnpack uUnpack (
    .in(req.dat),
    .fmt(req.adr),
    .rec(unpacked)
  );

  // ----------------------------------------------------------
  // response and push, one cycle after the request
  // ----------------------------------------------------------

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ackQ <= 1'b0;
      errQ <= 1'b0;
      push <= 1'b0;
      busy <= 1'b0;
    end else begin
      // full buffer drops the operand and reports err
      ackQ <= wrReq & (~full | ~toFifo);
      errQ <= wrReq & full & toFifo;
      push <= wrReq & ~full & toFifo;
      // held until the master lets go of stb
      busy <= wrReq | (busy & req.stb);
    end
  end

  // record travels with the push pulse
  always_ff @(posedge clk) begin
    if (wrReq) begin
      wrData <= unpacked;
    end
  end

  // write side returns no data
  assign rsp = '{ack: ackQ, err: errQ, dat: '0};

endmodule

// File: src.f
source/fpPkg.sv
source/fpUnpack.sv
source/wbOperandPort.sv
source/recordFifo.sv
source/fpClassify.sv
source/fpClassTop.sv
bench/fpClass_props.sv
bench/fpClassTb.sv
